/* hdl/uart_baud_gen.sv */
// ======================================================================
// Oversampling tick generator
// tick is one clock wide and fires every prescaler+1 clocks while en
// is high. With en low the count is frozen and no tick is produced
// ======================================================================

`timescale 1ns/1ps

module uart_baud_gen (
    input  logic        clk,
    input  logic        resetn,
    input  logic        en,
    input  logic [15:0] prescaler,
    output logic        tick
);

    logic [15:0] count;
    logic        wrap;

    assign wrap = (count == prescaler);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            count <= '0;
        end else if (en) begin
            if (wrap) begin
                count <= '0;
            end else begin
                count <= count + 16'd1;
            end
        end
    end

    assign tick = en & wrap;                // Held off while disabled

endmodule

/* hdl/uart_core_pkg.sv */
// ======================================================================
// Line states and status structs used inside the UART core
// FIFO_AW must equal the FAW parameter given to the FIFOs
// ======================================================================

package uart_core_pkg;

    localparam int FIFO_AW = 4;             // Depth 16

    // Frame position, shared by both serializers
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_PARITY,
        ST_STOP0,
        ST_STOP1
    } line_state_e;

    typedef struct packed {
        logic             empty;
        logic             full;
        logic [FIFO_AW:0] level;            // One bit wider so full reads as depth
    } fifo_status_t;

    // Single cycle pulses, aligned with the end of a received frame
    typedef struct packed {
        logic parity_error;
        logic frame_error;
        logic overrun;
    } rx_status_t;

endpackage

/* hdl/uart_fifo.sv */
// ======================================================================
// Synchronous show-ahead FIFO, depth 2**FAW
// rdata always shows the head word. Writes while full and reads while
// empty are ignored. FAW must match FIFO_AW of the status struct
// ======================================================================

`timescale 1ns/1ps

module uart_fifo
    import uart_core_pkg::*;
#(
    parameter int DW  = 8,
    parameter int FAW = 4
) (
    input  logic          clk,
    input  logic          resetn,
    input  logic          wr,
    input  logic [DW-1:0] wdata,
    input  logic          rd,
    output logic [DW-1:0] rdata,
    output fifo_status_t  status
);

    localparam logic [FAW:0] DEPTH = (FAW + 1)'(1 << FAW);

    logic [DW-1:0]  mem [2**FAW];
    logic [FAW-1:0] wr_ptr;
    logic [FAW-1:0] rd_ptr;
    logic [FAW:0]   count;
    logic           empty;
    logic           full;
    logic           do_wr;
    logic           do_rd;

    assign empty = (count == '0);
    assign full  = (count == DEPTH);
    assign do_wr = wr & ~full;
    assign do_rd = rd & ~empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the level alone
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    assign rdata = mem[rd_ptr];             // Head word

    assign status.empty = empty;
    assign status.full  = full;
    assign status.level = count;

endmodule

/* hdl/uart_frame_pkg.sv */
// ======================================================================
// Frame format types shared by the transmitter, receiver and top level
// data_size is only legal from 5 to 9 and is not range checked
// Parity codes match the codes used in the stimulus records
// ======================================================================

package uart_frame_pkg;

    localparam int MAX_DATA_W = 9;          // Widest data word

    typedef enum logic [2:0] {
        PAR_NONE    = 3'd0,
        PAR_ODD     = 3'd1,
        PAR_EVEN    = 3'd2,
        PAR_STICKY0 = 3'd4,
        PAR_STICKY1 = 3'd5
    } parity_e;

    typedef struct packed {
        logic [3:0] data_size;              // 5 to 9 data bits
        parity_e    parity;
        logic       two_stop;               // Set for two stop bits
    } frame_cfg_t;

    // Mask that keeps the low size bits of a word
    function automatic logic [MAX_DATA_W-1:0] data_mask(input logic [3:0] size);
        return ~({MAX_DATA_W{1'b1}} << size);
    endfunction

    // Parity bit for an already masked word
    function automatic logic parity_bit(input logic [MAX_DATA_W-1:0] d, input parity_e mode);
        logic p;
        case (mode)
            PAR_ODD:     p = ~^d;
            PAR_EVEN:    p = ^d;
            PAR_STICKY0: p = 1'b0;
            default:     p = 1'b1;          // Sticky 1 or parity off
        endcase
        return p;
    endfunction

endpackage

/* hdl/uart_rx.sv */
// ======================================================================
// UART receiver with a two flop input synchronizer
// Bits are sampled at their middle, SC/2 ticks after the start edge
// Errors are held for the frame and pulse together with done
// cfg may only change while the line is idle
// ======================================================================

`timescale 1ns/1ps

module uart_rx
    import uart_frame_pkg::*;
    import uart_core_pkg::*;
#(
    parameter int SC = 8
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  tick,
    input  frame_cfg_t            cfg,
    input  logic                  rx,
    output logic                  done,
    output logic [MAX_DATA_W-1:0] data,
    output logic                  parity_error,
    output logic                  frame_error
);

    localparam int SCW = $clog2(SC);

    line_state_e           state;
    line_state_e           state_nxt;
    logic                  rx_meta;
    logic                  rx_sync;
    logic [SCW-1:0]        smp_cnt;
    logic [3:0]            bit_cnt;
    logic [MAX_DATA_W-1:0] shreg;               // Fills from the top
    logic                  par_err;
    logic                  frm_err;
    logic                  mid_tick;
    logic                  bit_end;
    logic                  last_data;
    logic                  in_stop;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rx_meta <= 1'b1;                    // Idle line level
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign mid_tick  = tick && (smp_cnt == SCW'(SC / 2 - 1));
    assign bit_end   = tick && (smp_cnt == SCW'(SC - 1));
    assign last_data = (bit_cnt == cfg.data_size - 4'd1);
    assign in_stop   = (state == ST_STOP0) || (state == ST_STOP1);
    assign data      = shreg >> (4'(MAX_DATA_W) - cfg.data_size);

    always_comb begin
        state_nxt = state;
        done      = 1'b0;
        case (state)
            ST_IDLE: begin
                if (tick && !rx_sync) state_nxt = ST_START;
            end
            ST_START: begin
                if (mid_tick) state_nxt = ST_DATA;   // Now aligned to bit middles
            end
            ST_DATA: begin
                if (bit_end && last_data) begin
                    state_nxt = (cfg.parity == PAR_NONE) ? ST_STOP0 : ST_PARITY;
                end
            end
            ST_PARITY: begin
                if (bit_end) state_nxt = ST_STOP0;
            end
            ST_STOP0: begin
                if (bit_end) begin
                    state_nxt = cfg.two_stop ? ST_STOP1 : ST_IDLE;
                    done      = ~cfg.two_stop;
                end
            end
            ST_STOP1: begin
                if (bit_end) begin
                    state_nxt = ST_IDLE;
                    done      = 1'b1;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state   <= ST_IDLE;
            smp_cnt <= '0;
            bit_cnt <= '0;
            par_err <= 1'b0;
            frm_err <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == ST_IDLE || (state == ST_START && mid_tick) || bit_end) begin
                smp_cnt <= '0;
            end else if (tick) begin
                smp_cnt <= smp_cnt + 1'b1;
            end
            if (state != ST_DATA) begin
                bit_cnt <= '0;
            end else if (bit_end) begin
                bit_cnt <= bit_cnt + 4'd1;
            end
            if (state == ST_IDLE) begin
                par_err <= 1'b0;
                frm_err <= 1'b0;
            end else begin
                if (state == ST_PARITY && bit_end) begin
                    par_err <= (rx_sync != parity_bit(data, cfg.parity));
                end
                if (in_stop && bit_end && !rx_sync) begin
                    frm_err <= 1'b1;            // Any low stop bit
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_DATA && bit_end) begin
            shreg <= {rx_sync, shreg[MAX_DATA_W-1:1]};
        end
    end

    // The last stop bit is checked in the same cycle as done
    assign parity_error = done & par_err;
    assign frame_error  = done & (frm_err | ~rx_sync);

endmodule

/* hdl/uart_top.sv */
// ======================================================================
// UART top level with TX and RX FIFOs and a shared baud generator
// Change cfg only while both lines are idle and both FIFOs are empty
// FAW must equal FIFO_AW. SC must be even and at least 4
// ======================================================================

`timescale 1ns/1ps

module uart_top
    import uart_frame_pkg::*;
    import uart_core_pkg::*;
#(
    parameter int FAW = 4,
    parameter int SC  = 8
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [15:0]           prescaler,
    input  logic                  en,
    input  frame_cfg_t            cfg,
    input  logic                  wr,
    input  logic [MAX_DATA_W-1:0] wdata,
    input  logic                  rd,
    input  logic                  rx,
    output logic                  tx,
    output logic [MAX_DATA_W-1:0] rdata,
    output fifo_status_t          tx_status,
    output fifo_status_t          rx_status,
    output rx_status_t            flags
);

    logic                  tick;
    logic                  tx_done;
    logic                  rx_done;
    logic                  rx_wr;
    logic                  rx_par_err;
    logic                  rx_frm_err;
    logic [MAX_DATA_W-1:0] tx_head;
    logic [MAX_DATA_W-1:0] rx_word;

    uart_baud_gen u_baud_gen (
        .clk       (clk),
        .resetn    (resetn),
        .en        (en),
        .prescaler (prescaler),
        .tick      (tick)
    );

    uart_fifo #(.DW(MAX_DATA_W), .FAW(FAW)) u_tx_fifo (
        .clk    (clk),
        .resetn (resetn),
        .wr     (wr),
        .wdata  (wdata),
        .rd     (tx_done),                  // Pop once the frame has left
        .rdata  (tx_head),
        .status (tx_status)
    );

    uart_tx #(.SC(SC)) u_tx (
        .clk    (clk),
        .resetn (resetn),
        .tick   (tick),
        .cfg    (cfg),
        .start  (~tx_status.empty),
        .data   (tx_head),
        .done   (tx_done),
        .tx     (tx)
    );

    uart_rx #(.SC(SC)) u_rx (
        .clk          (clk),
        .resetn       (resetn),
        .tick         (tick),
        .cfg          (cfg),
        .rx           (rx),
        .done         (rx_done),
        .data         (rx_word),
        .parity_error (rx_par_err),
        .frame_error  (rx_frm_err)
    );

    // A full RX FIFO drops the frame and reports overrun instead
    assign rx_wr = rx_done & ~rx_status.full;

    uart_fifo #(.DW(MAX_DATA_W), .FAW(FAW)) u_rx_fifo (
        .clk    (clk),
        .resetn (resetn),
        .wr     (rx_wr),
        .wdata  (rx_word),
        .rd     (rd),
        .rdata  (rdata),
        .status (rx_status)
    );

    assign flags.parity_error = rx_par_err;
    assign flags.frame_error  = rx_frm_err;
    assign flags.overrun      = rx_done & rx_status.full;

endmodule

/* hdl/uart_tx.sv */
// ======================================================================
// UART transmitter, one frame per non-empty FIFO head
// Every bit lasts SC ticks. The head word must stay stable until done
// cfg may only change while the line is idle
// ======================================================================

`timescale 1ns/1ps

module uart_tx
    import uart_frame_pkg::*;
    import uart_core_pkg::*;
#(
    parameter int SC = 8
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  tick,
    input  frame_cfg_t            cfg,
    input  logic                  start,
    input  logic [MAX_DATA_W-1:0] data,
    output logic                  done,
    output logic                  tx
);

    localparam int SCW = $clog2(SC);

    line_state_e           state;
    line_state_e           state_nxt;
    logic [SCW-1:0]        smp_cnt;             // Ticks within the bit
    logic [3:0]            bit_cnt;             // Data bits already sent
    logic [MAX_DATA_W-1:0] shreg;
    logic [MAX_DATA_W-1:0] masked;
    logic                  par_q;
    logic                  bit_end;
    logic                  last_data;
    logic                  load;
    logic                  tx_nxt;

    assign masked    = data & data_mask(cfg.data_size);
    assign bit_end   = tick && (smp_cnt == SCW'(SC - 1));
    assign last_data = (bit_cnt == cfg.data_size - 4'd1);
    assign load      = (state == ST_IDLE) && start;

    always_comb begin
        state_nxt = state;
        done      = 1'b0;
        case (state)
            ST_IDLE: begin
                if (start) state_nxt = ST_START;     // No need to wait for a tick
            end
            ST_START: begin
                if (bit_end) state_nxt = ST_DATA;
            end
            ST_DATA: begin
                if (bit_end && last_data) begin
                    state_nxt = (cfg.parity == PAR_NONE) ? ST_STOP0 : ST_PARITY;
                end
            end
            ST_PARITY: begin
                if (bit_end) state_nxt = ST_STOP0;
            end
            ST_STOP0: begin
                if (bit_end) begin
                    state_nxt = cfg.two_stop ? ST_STOP1 : ST_IDLE;
                    done      = ~cfg.two_stop;
                end
            end
            ST_STOP1: begin
                if (bit_end) begin
                    state_nxt = ST_IDLE;
                    done      = 1'b1;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // Line level for the current frame position
    always_comb begin
        case (state)
            ST_START:  tx_nxt = 1'b0;
            ST_DATA:   tx_nxt = shreg[0];
            ST_PARITY: tx_nxt = par_q;
            default:   tx_nxt = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state   <= ST_IDLE;
            smp_cnt <= '0;
            bit_cnt <= '0;
            tx      <= 1'b1;
        end else begin
            state <= state_nxt;
            tx    <= tx_nxt;
            if (state == ST_IDLE || bit_end) begin
                smp_cnt <= '0;
            end else if (tick) begin
                smp_cnt <= smp_cnt + 1'b1;
            end
            if (state != ST_DATA) begin
                bit_cnt <= '0;
            end else if (bit_end) begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= masked;
            par_q <= parity_bit(masked, cfg.parity);
        end else if (state == ST_DATA && bit_end) begin
            shreg <= shreg >> 1;                     // LSB first
        end
    end

endmodule

/* test/uart_stim.txt */
# kind size parity stops data(hex), parity 0 none 1 odd 2 even 4 sticky0 5 sticky1
# T transmit, R good receive, P bad parity, F low first stop bit, O burst of 17 frames
T 8 0 1 0a5
T 5 1 1 1f3
T 7 2 2 07e
T 9 4 1 1c3
T 6 5 2 02a
T 9 1 2 155
T 8 2 1 0ff
R 8 0 1 03c
R 5 2 1 0f9
R 9 1 2 1a6
R 7 4 1 055
R 6 5 2 021
R 8 1 1 080
P 8 1 1 0c3
P 7 2 2 01b
P 9 2 1 100
F 8 0 2 05a
F 6 1 2 033
R 8 0 1 0e7
O 8 2 1 010

/* test/uart_top_tb.sv */
// ======================================================================
// Self-checking testbench for the UART top level
// Records come from test/uart_stim.txt relative to the project root
// Prescaler 3 with SC 8 gives a bit time of 32 clocks
// Serial lines are sampled near bit middles rather than at exact edges
// F records need two stop bits because a low single stop looks like a start
// ======================================================================

`timescale 1ns/1ps

module uart_top_tb
    import uart_frame_pkg::*;
    import uart_core_pkg::*;
();

    localparam int BIT_CLKS      = 32;      // SC * (prescaler + 1)
    localparam int TIMEOUT       = 2000;    // Cycles allowed for one wait
    localparam int WAIT_TX_LOW   = 0;
    localparam int WAIT_TX_EMPTY = 1;
    localparam int WAIT_RX_DATA  = 2;

    logic                  clk;
    logic                  resetn;
    logic [15:0]           prescaler;
    logic                  en;
    frame_cfg_t            cfg;
    logic                  wr;
    logic [MAX_DATA_W-1:0] wdata;
    logic                  rd;
    logic                  rx;
    logic                  tx;
    logic [MAX_DATA_W-1:0] rdata;
    fifo_status_t          tx_status;
    fifo_status_t          rx_status;
    rx_status_t            flags;
    rx_status_t            seen_flags;      // OR of flags while the line model runs
    int                    pulse_cycles;    // Cycles with any flag set

    uart_top u_uart_top (
        .clk       (clk),
        .resetn    (resetn),
        .prescaler (prescaler),
        .en        (en),
        .cfg       (cfg),
        .wr        (wr),
        .wdata     (wdata),
        .rd        (rd),
        .rx        (rx),
        .tx        (tx),
        .rdata     (rdata),
        .tx_status (tx_status),
        .rx_status (rx_status),
        .flags     (flags)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [MAX_DATA_W-1:0] keep_low_bits(input int d, input int size);
        logic [MAX_DATA_W-1:0] m;
        int                    i;
        m = '0;
        for (i = 0; i < size; i++) begin
            m[i] = d[i];
        end
        return m;
    endfunction

    // Odd sends the inverted XOR and sticky modes send a constant
    function automatic logic line_parity(input logic [MAX_DATA_W-1:0] d, input int mode);
        logic p;
        case (mode)
            1:       p = ~^d;
            2:       p = ^d;
            4:       p = 1'b0;
            default: p = 1'b1;
        endcase
        return p;
    endfunction

    function automatic fifo_status_t fifo_state(input logic e, input logic f, input int lvl);
        fifo_status_t s;
        s.empty = e;
        s.full  = f;
        s.level = lvl[FIFO_AW:0];
        return s;
    endfunction

    function automatic string fifo_text(input fifo_status_t s);
        return $sformatf("empty=%0b full=%0b level=%0d", s.empty, s.full, s.level);
    endfunction

    function automatic string flags_text(input rx_status_t s);
        return $sformatf("parity=%0b frame=%0b overrun=%0b",
                         s.parity_error, s.frame_error, s.overrun);
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [MAX_DATA_W-1:0] got,
                              input logic [MAX_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_fifo(input string name, input fifo_status_t got,
                              input fifo_status_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s expected %s got %s", $time, name,
                     fifo_text(exp), fifo_text(got));
            abort_run();
        end
    endtask

    task automatic check_flags(input string name, input rx_status_t got, input rx_status_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s expected %s got %s", $time, name,
                     flags_text(exp), flags_text(got));
            abort_run();
        end
    endtask

    task automatic wait_for(input int what, input string desc);
        int   n;
        logic ok;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            case (what)
                WAIT_TX_LOW:   ok = (tx == 1'b0);
                WAIT_TX_EMPTY: ok = tx_status.empty;
                default:       ok = !rx_status.empty;
            endcase
            if (!ok && n > TIMEOUT) begin
                $display("Timeout after %0d cycles waiting for %s", n, desc);
                abort_run();
            end
        end while (!ok);
    endtask

    task automatic idle_gap();
        repeat ($urandom % 24) @(posedge clk);
    endtask

    task automatic set_format(input int size, input int par, input int stops);
        @(posedge clk);
        cfg.data_size <= 4'(size);
        cfg.parity    <= parity_e'(par);
        cfg.two_stop  <= (stops == 2);
    endtask

    task automatic push_word(input logic [MAX_DATA_W-1:0] d);
        @(posedge clk);
        wr    <= 1'b1;
        wdata <= d;
        @(posedge clk);
        wr    <= 1'b0;
    endtask

    task automatic pop_word();
        @(posedge clk);
        rd <= 1'b1;
        @(posedge clk);
        rd <= 1'b0;
    endtask

    // Line model step that holds one bit and collects flag pulses meanwhile
    task automatic drive_bit(input logic b);
        int i;
        rx <= b;                            // Called right after a rising edge
        for (i = 0; i < BIT_CLKS; i++) begin
            @(negedge clk);
            if (flags != '0) begin
                seen_flags   = seen_flags | flags;
                pulse_cycles = pulse_cycles + 1;
            end
            @(posedge clk);
        end
    endtask

    task automatic send_frame(input logic [MAX_DATA_W-1:0] d, input int size, input int par,
                              input int stops, input bit bad_par, input bit bad_stop);
        int i;
        @(posedge clk);
        drive_bit(1'b0);
        for (i = 0; i < size; i++) begin
            drive_bit(d[i]);
        end
        if (par != 0) begin
            drive_bit(line_parity(d, par) ^ bad_par);
        end
        drive_bit(~bad_stop);               // Only the first stop bit is ever low
        if (stops == 2) begin
            drive_bit(1'b1);
        end
    endtask

    // Monitor for one tx frame. Set started when the start bit is already on the line
    task automatic check_tx_frame(input logic [MAX_DATA_W-1:0] exp, input int size,
                                  input int par, input int stops, input bit started);
        logic [MAX_DATA_W-1:0] got;
        logic [3:0]            frame_bits;  // Stop1, stop0, parity, start
        logic [3:0]            exp_bits;
        int                    i;
        got        = '0;
        frame_bits = '0;
        exp_bits   = 4'b0100;
        if (!started) begin
            wait_for(WAIT_TX_LOW, "a start bit on tx");
        end
        repeat (BIT_CLKS / 2) @(negedge clk);
        frame_bits[0] = tx;
        for (i = 0; i < size; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            got[i] = tx;
        end
        if (par != 0) begin
            repeat (BIT_CLKS) @(negedge clk);
            frame_bits[1] = tx;
            exp_bits[1]   = line_parity(exp, par);
        end
        repeat (BIT_CLKS) @(negedge clk);
        frame_bits[2] = tx;
        if (stops == 2) begin
            repeat (BIT_CLKS) @(negedge clk);
            frame_bits[3] = tx;
            exp_bits[3]   = 1'b1;
        end
        check_word("tx data bits", got, exp);
        check_word("tx start, parity and stop bits", MAX_DATA_W'(frame_bits),
                   MAX_DATA_W'(exp_bits));
    endtask

    task automatic transmit_check(input int d, input int size, input int par, input int stops);
        push_word(d[MAX_DATA_W-1:0]);       // High bits must not reach the line
        check_tx_frame(keep_low_bits(d, size), size, par, stops, 1'b0);
        wait_for(WAIT_TX_EMPTY, "the TX FIFO to drain");
        check_fifo("tx_status", tx_status, fifo_state(1'b1, 1'b0, 0));
    endtask

    task automatic receive_check(input byte kind, input int d, input int size, input int par,
                                 input int stops);
        rx_status_t            exp_flags;
        logic [MAX_DATA_W-1:0] exp;
        exp                    = keep_low_bits(d, size);
        exp_flags              = '0;
        exp_flags.parity_error = (kind == "P");
        exp_flags.frame_error  = (kind == "F");
        seen_flags             = '0;
        pulse_cycles           = 0;
        send_frame(exp, size, par, stops, kind == "P", kind == "F");
        check_flags("flags", seen_flags, exp_flags);
        check_word("flag pulse cycles", MAX_DATA_W'(pulse_cycles), MAX_DATA_W'(exp_flags != '0));
        wait_for(WAIT_RX_DATA, "a word in the RX FIFO");
        check_word("rdata", rdata, exp);
        pop_word();
        @(negedge clk);
        check_fifo("rx_status", rx_status, fifo_state(1'b1, 1'b0, 0));
    endtask

    task automatic overrun_check(input int d, input int size, input int par, input int stops);
        rx_status_t exp_flags;
        int         i;
        for (i = 0; i < 17; i++) begin
            exp_flags         = '0;
            exp_flags.overrun = (i == 16);  // Only the frame that finds the FIFO full
            seen_flags        = '0;
            pulse_cycles      = 0;
            send_frame(keep_low_bits(d + i, size), size, par, stops, 1'b0, 1'b0);
            check_flags("flags", seen_flags, exp_flags);
            check_word("flag pulse cycles", MAX_DATA_W'(pulse_cycles), MAX_DATA_W'(i == 16));
            idle_gap();
        end
        @(negedge clk);
        check_fifo("rx_status", rx_status, fifo_state(1'b0, 1'b1, 16));
        for (i = 0; i < 16; i++) begin
            @(negedge clk);
            check_word("rdata", rdata, keep_low_bits(d + i, size));
            pop_word();
        end
        @(negedge clk);
        check_fifo("rx_status", rx_status, fifo_state(1'b1, 1'b0, 0));
    endtask

    task automatic fill_check();
        logic [MAX_DATA_W-1:0] words [17];
        int                    i;
        set_format(8, 2, 1);
        @(posedge clk);
        en <= 1'b0;
        for (i = 0; i < 17; i++) begin
            words[i] = MAX_DATA_W'((i * 29) ^ 8'h5a);
            push_word(words[i]);
        end
        repeat (4 * BIT_CLKS) @(negedge clk);
        check_fifo("tx_status", tx_status, fifo_state(1'b0, 1'b1, 16));
        check_word("tx", MAX_DATA_W'(tx), '0);  // Start bit frozen without ticks
        @(posedge clk);
        en <= 1'b1;
        for (i = 0; i < 16; i++) begin
            check_tx_frame(keep_low_bits(words[i], 8), 8, 2, 1, i == 0);
        end
        wait_for(WAIT_TX_EMPTY, "the TX FIFO to drain");
        repeat (2 * BIT_CLKS) @(negedge clk);
        check_word("tx", MAX_DATA_W'(tx), MAX_DATA_W'(1));
        check_fifo("tx_status", tx_status, fifo_state(1'b1, 1'b0, 0));
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        byte   kind;
        int    size;
        int    par;
        int    stops;
        int    data;
        void'($urandom(32'hf680e4c3));
        resetn       = 1'b0;
        prescaler    = 16'd3;
        en           = 1'b1;
        cfg          = '{data_size: 4'd8, parity: PAR_NONE, two_stop: 1'b0};
        wr           = 1'b0;
        wdata        = '0;
        rd           = 1'b0;
        rx           = 1'b1;
        seen_flags   = '0;
        pulse_cycles = 0;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_word("tx", MAX_DATA_W'(tx), MAX_DATA_W'(1));
        check_fifo("tx_status", tx_status, fifo_state(1'b1, 1'b0, 0));
        check_fifo("rx_status", rx_status, fifo_state(1'b1, 1'b0, 0));
        @(posedge clk);
        drive_bit(1'b1);                    // No flag may move on an idle line
        check_flags("flags", seen_flags, '0);
        fd = $fopen("test/uart_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file test/uart_stim.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 2 && line[0] != "#") begin
                n = $sscanf(line, "%c %d %d %d %h", kind, size, par, stops, data);
                if (n != 5) begin
                    $display("Malformed stimulus record: %s", line);
                    abort_run();
                end
                set_format(size, par, stops);
                case (kind)
                    "T":           transmit_check(data, size, par, stops);
                    "R", "P", "F": receive_check(kind, data, size, par, stops);
                    "O":           overrun_check(data, size, par, stops);
                    default: begin
                        $display("Unknown record kind in the stimulus file: %s", line);
                        abort_run();
                    end
                endcase
                idle_gap();
            end
        end
        $fclose(fd);
        fill_check();
        $display("Simulation passed");
        $finish;
    end

endmodule

/* uart_top.f */
hdl/uart_frame_pkg.sv
hdl/uart_core_pkg.sv
hdl/uart_baud_gen.sv
hdl/uart_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_top.sv
test/uart_top_tb.sv
